// ==== verilog/pipePkg.sv ====
package pipePkg;

	localparam int REG_ADDR_WIDTH = 5;
	localparam int OP_WIDTH = 4;
	localparam int IMM_WIDTH = 13;

	// Operation codes, top field of the instruction word
	typedef enum logic [OP_WIDTH-1:0] {
		opNop,
		opAdd,
		opSub,
		opAnd,
		opOr,
		opSlt,
		opLw,
		opSw,
		opBeq
	} opcodeT;

	// One instruction, exactly one 32-bit word
	typedef struct packed {
		opcodeT op;
		logic [REG_ADDR_WIDTH-1:0] rs;
		logic [REG_ADDR_WIDTH-1:0] rt;
		logic [REG_ADDR_WIDTH-1:0] rd;
		logic signed [IMM_WIDTH-1:0] imm;
	} instrT;

	// Operand source, fwdNone means the register file value
	typedef enum logic [1:0] {
		fwdNone = 2'b00,
		fwdMemWb = 2'b01,
		fwdExMem = 2'b10,
		fwdIdEx = 2'b11
	} fwdSelT;

endpackage

// ==== verilog/hazardIf.sv ====
`timescale 1ns/10ps

interface hazardIf;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] ifidRs;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] ifidRt;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] idexRs;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] idexRt;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] idexRd;
	logic idexRegWrite;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] exmemRd;
	logic exmemRegWrite;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] memwbRd;
	logic memwbRegWrite;
	logic branchInId;

	// Write enables already include the stage valid bit
	modport ctrl (
		output ifidRs, ifidRt, idexRs, idexRt, idexRd, idexRegWrite,
		output exmemRd, exmemRegWrite, memwbRd, memwbRegWrite, branchInId
	);

	modport fwd (
		input ifidRs, ifidRt, idexRs, idexRt, idexRd, idexRegWrite,
		input exmemRd, exmemRegWrite, memwbRd, memwbRegWrite, branchInId
	);
endinterface

// ==== verilog/forwardUnit.sv ====
`timescale 1ns/10ps

module forwardUnit (
	input logic reset,
	hazardIf.fwd hz,
	output pipePkg::fwdSelT fwdA,
	output pipePkg::fwdSelT fwdB,
	output pipePkg::fwdSelT fwdC,
	output pipePkg::fwdSelT fwdD
);

	// Execute operands, EX/MEM is newer than MEM/WB
	function automatic pipePkg::fwdSelT aluSel(input logic [pipePkg::REG_ADDR_WIDTH-1:0] src);
		if (src == '0)
			return pipePkg::fwdNone;
		if (hz.exmemRegWrite && hz.exmemRd == src)
			return pipePkg::fwdExMem;
		if (hz.memwbRegWrite && hz.memwbRd == src)
			return pipePkg::fwdMemWb;
		return pipePkg::fwdNone;
	endfunction

	// Branch operands in decode can also take the result now in execute
	function automatic pipePkg::fwdSelT branchSel(input logic [pipePkg::REG_ADDR_WIDTH-1:0] src);
		if (src == '0)
			return pipePkg::fwdNone;
		if (hz.idexRegWrite && hz.idexRd == src)
			return pipePkg::fwdIdEx;
		return aluSel(src);
	endfunction

	always_comb begin
		if (!reset) begin
			fwdA = pipePkg::fwdNone;
			fwdB = pipePkg::fwdNone;
			fwdC = pipePkg::fwdNone;
			fwdD = pipePkg::fwdNone;
		end else begin
			fwdA = aluSel(hz.idexRs);
			fwdB = aluSel(hz.idexRt);
			fwdC = hz.branchInId ? branchSel(hz.ifidRs) : pipePkg::fwdNone;
			fwdD = hz.branchInId ? branchSel(hz.ifidRt) : pipePkg::fwdNone;
		end
	end

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/10ps

module regFile #(
	parameter int DATA_WIDTH = 32
) (
	input logic clk,
	input logic reset,
	input logic [pipePkg::REG_ADDR_WIDTH-1:0] rsAddr,
	input logic [pipePkg::REG_ADDR_WIDTH-1:0] rtAddr,
	output logic [DATA_WIDTH-1:0] rsData,
	output logic [DATA_WIDTH-1:0] rtData,
	input logic wbWrite,
	input logic [pipePkg::REG_ADDR_WIDTH-1:0] wbRd,
	input logic [DATA_WIDTH-1:0] wbData
);

	localparam int NUM_REGS = 2 ** pipePkg::REG_ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] regs [NUM_REGS];

	// Register zero is never written so it stays at its reset value
	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wbWrite && wbRd != '0) begin
			regs[wbRd] <= wbData;
		end
	end

	// Write-through so decode sees the value written this cycle
	function automatic logic [DATA_WIDTH-1:0] readPort(
		input logic [pipePkg::REG_ADDR_WIDTH-1:0] addr);
		if (addr == '0)
			return '0;
		if (wbWrite && wbRd == addr)
			return wbData;
		return regs[addr];
	endfunction

	always_comb begin
		rsData = readPort(rsAddr);
		rtData = readPort(rtAddr);
	end

endmodule

// ==== verilog/branchResolve.sv ====
`timescale 1ns/10ps

module branchResolve #(
	parameter int DATA_WIDTH = 32
) (
	input logic clk,
	input logic reset,
	input logic branchInId,
	input logic stall,
	input logic [DATA_WIDTH-1:0] rsData,
	input logic [DATA_WIDTH-1:0] rtData,
	input logic signed [pipePkg::IMM_WIDTH-1:0] idImm,
	input pipePkg::fwdSelT fwdC,
	input pipePkg::fwdSelT fwdD,
	input logic [DATA_WIDTH-1:0] exAluResult,
	input logic [DATA_WIDTH-1:0] exmemResult,
	input logic [DATA_WIDTH-1:0] wbData,
	output logic branchValid,
	output logic branchTaken,
	output logic signed [pipePkg::IMM_WIDTH-1:0] branchTarget
);

	logic [DATA_WIDTH-1:0] cmpA;
	logic [DATA_WIDTH-1:0] cmpB;

	function automatic logic [DATA_WIDTH-1:0] pickOperand(
		input pipePkg::fwdSelT sel,
		input logic [DATA_WIDTH-1:0] regVal);
		case (sel)
			pipePkg::fwdIdEx: return exAluResult;
			pipePkg::fwdExMem: return exmemResult;
			pipePkg::fwdMemWb: return wbData;
			default: return regVal;
		endcase
	endfunction

	always_comb begin
		cmpA = pickOperand(fwdC, rsData);
		cmpB = pickOperand(fwdD, rtData);
	end

	always_ff @(posedge clk) begin
		if (!reset)
			branchValid <= 1'b0;
		else
			branchValid <= branchInId && !stall;
	end

	// Outcome captured only when the branch leaves decode
	always_ff @(posedge clk) begin
		if (branchInId && !stall) begin
			branchTaken <= (cmpA == cmpB);
			branchTarget <= idImm;
		end
	end

endmodule

// ==== verilog/aluExecute.sv ====
`timescale 1ns/10ps

module aluExecute #(
	parameter int DATA_WIDTH = 32
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic [DATA_WIDTH-1:0] rsData,
	input logic [DATA_WIDTH-1:0] rtData,
	input pipePkg::opcodeT idOp,
	input logic signed [pipePkg::IMM_WIDTH-1:0] idImm,
	input logic idUseImm,
	input pipePkg::fwdSelT fwdA,
	input pipePkg::fwdSelT fwdB,
	input logic [DATA_WIDTH-1:0] wbData,
	output logic [DATA_WIDTH-1:0] exAluResult,
	output logic [DATA_WIDTH-1:0] exmemResult,
	output logic [DATA_WIDTH-1:0] exmemStoreData
);

	pipePkg::opcodeT idexOp;
	logic [DATA_WIDTH-1:0] idexA;
	logic [DATA_WIDTH-1:0] idexB;
	logic [DATA_WIDTH-1:0] idexImm;
	logic idexUseImm;
	logic [DATA_WIDTH-1:0] opA;
	logic [DATA_WIDTH-1:0] opB;
	logic [DATA_WIDTH-1:0] aluB;

	// Stall turns the entering instruction into a nop
	always_ff @(posedge clk) begin
		if (!reset || stall)
			idexOp <= pipePkg::opNop;
		else
			idexOp <= idOp;
	end

	always_ff @(posedge clk) begin
		idexA <= rsData;
		idexB <= rtData;
		idexImm <= {{(DATA_WIDTH - pipePkg::IMM_WIDTH){idImm[pipePkg::IMM_WIDTH-1]}}, idImm};
		idexUseImm <= idUseImm;
	end

	always_comb begin
		case (fwdA)
			pipePkg::fwdExMem: opA = exmemResult;
			pipePkg::fwdMemWb: opA = wbData;
			default: opA = idexA;
		endcase
		case (fwdB)
			pipePkg::fwdExMem: opB = exmemResult;
			pipePkg::fwdMemWb: opB = wbData;
			default: opB = idexB;
		endcase
		// Loads and stores add the immediate to rs for the word index
		aluB = idexUseImm ? idexImm : opB;
		case (idexOp)
			pipePkg::opAdd, pipePkg::opLw, pipePkg::opSw: exAluResult = opA + aluB;
			pipePkg::opSub: exAluResult = opA - aluB;
			pipePkg::opAnd: exAluResult = opA & aluB;
			pipePkg::opOr: exAluResult = opA | aluB;
			pipePkg::opSlt: exAluResult = DATA_WIDTH'($signed(opA) < $signed(aluB));
			default: exAluResult = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		exmemResult <= exAluResult;
		exmemStoreData <= opB;
	end

endmodule

// ==== verilog/dataMem.sv ====
`timescale 1ns/10ps

module dataMem #(
	parameter int DATA_WIDTH = 32,
	parameter int MEM_WORDS = 16
) (
	input logic clk,
	input logic reset,
	input logic memRead,
	input logic memWrite,
	input logic [DATA_WIDTH-1:0] exmemResult,
	input logic [DATA_WIDTH-1:0] exmemStoreData,
	output logic [DATA_WIDTH-1:0] wbData
);

	localparam int ADDR_WIDTH = $clog2(MEM_WORDS);

	logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
	logic [ADDR_WIDTH-1:0] addr;

	// Word index wraps on the low bits
	assign addr = exmemResult[ADDR_WIDTH-1:0];

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= '0;
		end else if (memWrite) begin
			mem[addr] <= exmemStoreData;
		end
	end

	always_ff @(posedge clk)
		wbData <= memRead ? mem[addr] : exmemResult;

endmodule

// ==== verilog/pipeControl.sv ====
`timescale 1ns/10ps

module pipeControl (
	input logic clk,
	input logic reset,
	input pipePkg::instrT instr,
	input logic instrValid,
	output logic stall,
	hazardIf.ctrl hz,
	output logic [pipePkg::REG_ADDR_WIDTH-1:0] rsAddr,
	output logic [pipePkg::REG_ADDR_WIDTH-1:0] rtAddr,
	output pipePkg::opcodeT idOp,
	output logic signed [pipePkg::IMM_WIDTH-1:0] idImm,
	output logic idUseImm,
	output logic memRead,
	output logic memWrite,
	output logic wbWrite,
	output logic [pipePkg::REG_ADDR_WIDTH-1:0] wbRd,
	output logic wbValid,
	output logic branchInId
);

	pipePkg::instrT ifidInstr;
	logic ifidValid;
	pipePkg::opcodeT idexOp;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] idexRs;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] idexRt;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] idexRd;
	logic idexRegWrite;
	logic idexValid;
	pipePkg::opcodeT exmemOp;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] exmemRd;
	logic exmemRegWrite;
	logic exmemValid;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] memwbRd;
	logic memwbRegWrite;
	logic memwbValid;
	logic usesRs;
	logic usesRt;
	logic idRegWrite;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] idDest;
	logic loadUse;
	logic branchOnLoad;

	// Decode of the instruction held in IF/ID
	always_comb begin
		usesRs = 1'b0;
		usesRt = 1'b0;
		idRegWrite = 1'b0;
		idDest = ifidInstr.rd;
		case (ifidInstr.op)
			pipePkg::opAdd, pipePkg::opSub, pipePkg::opAnd, pipePkg::opOr, pipePkg::opSlt: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
				idRegWrite = 1'b1;
			end
			pipePkg::opLw: begin
				usesRs = 1'b1;
				idRegWrite = 1'b1;
				idDest = ifidInstr.rt;
			end
			pipePkg::opSw, pipePkg::opBeq: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
			end
			default: idRegWrite = 1'b0;
		endcase
		if (idDest == '0)
			idRegWrite = 1'b0;
	end

	assign idOp = ifidValid ? ifidInstr.op : pipePkg::opNop;
	assign idImm = ifidInstr.imm;
	assign idUseImm = (ifidInstr.op == pipePkg::opLw) || (ifidInstr.op == pipePkg::opSw);
	assign rsAddr = ifidInstr.rs;
	assign rtAddr = ifidInstr.rt;
	assign branchInId = ifidValid && (ifidInstr.op == pipePkg::opBeq);

	// Load in execute whose word the decode instruction needs
	assign loadUse = idexValid && idexRegWrite && (idexOp == pipePkg::opLw) &&
		((usesRs && idexRd == ifidInstr.rs) || (usesRt && idexRd == ifidInstr.rt));
	// Branch compare cannot use a load still in the memory stage
	assign branchOnLoad = branchInId && exmemValid && exmemRegWrite &&
		(exmemOp == pipePkg::opLw) && (exmemRd == ifidInstr.rs || exmemRd == ifidInstr.rt);
	assign stall = ifidValid && (loadUse || branchOnLoad);

	always_ff @(posedge clk) begin
		if (!reset) begin
			ifidValid <= 1'b0;
			idexValid <= 1'b0;
			exmemValid <= 1'b0;
			memwbValid <= 1'b0;
		end else begin
			if (!stall)
				ifidValid <= instrValid;
			idexValid <= ifidValid && !stall;
			exmemValid <= idexValid;
			memwbValid <= exmemValid;
		end
	end

	// IF/ID holds during a stall, later stages always advance
	always_ff @(posedge clk) begin
		if (!stall)
			ifidInstr <= instr;
		idexOp <= idOp;
		idexRs <= ifidInstr.rs;
		idexRt <= ifidInstr.rt;
		idexRd <= idDest;
		idexRegWrite <= idRegWrite;
		exmemOp <= idexOp;
		exmemRd <= idexRd;
		exmemRegWrite <= idexRegWrite;
		memwbRd <= exmemRd;
		memwbRegWrite <= exmemRegWrite;
	end

	assign memRead = exmemValid && (exmemOp == pipePkg::opLw);
	assign memWrite = exmemValid && (exmemOp == pipePkg::opSw);
	assign wbValid = memwbValid && memwbRegWrite;
	assign wbWrite = wbValid;
	assign wbRd = memwbRd;

	assign hz.ifidRs = ifidInstr.rs;
	assign hz.ifidRt = ifidInstr.rt;
	assign hz.idexRs = idexRs;
	assign hz.idexRt = idexRt;
	assign hz.idexRd = idexRd;
	assign hz.idexRegWrite = idexValid && idexRegWrite;
	assign hz.exmemRd = exmemRd;
	assign hz.exmemRegWrite = exmemValid && exmemRegWrite;
	assign hz.memwbRd = memwbRd;
	assign hz.memwbRegWrite = memwbValid && memwbRegWrite;
	assign hz.branchInId = branchInId;

	// No write report in the cycle after a reset edge
	assert property (@(posedge clk) !reset |=> !wbValid)
		else $error("pipeControl: wbValid high while in reset");

	// A stall keeps the same valid instruction in IF/ID
	assert property (@(posedge clk) disable iff (!reset)
		stall |-> ifidValid ##1 (ifidValid && $stable(ifidInstr)))
		else $error("pipeControl: stall without a held IF/ID instruction");

endmodule

// ==== verilog/pipeCore.sv ====
`timescale 1ns/10ps

module pipeCore #(
	parameter int DATA_WIDTH = 32,
	parameter int MEM_WORDS = 16
) (
	input logic clk,
	input logic reset,
	input pipePkg::instrT instr,
	input logic instrValid,
	output logic stall,
	output logic wbValid,
	output logic [pipePkg::REG_ADDR_WIDTH-1:0] wbRd,
	output logic [DATA_WIDTH-1:0] wbData,
	output logic branchValid,
	output logic branchTaken,
	output logic signed [pipePkg::IMM_WIDTH-1:0] branchTarget
);

	logic [pipePkg::REG_ADDR_WIDTH-1:0] rsAddr;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] rtAddr;
	logic [DATA_WIDTH-1:0] rsData;
	logic [DATA_WIDTH-1:0] rtData;
	pipePkg::opcodeT idOp;
	logic signed [pipePkg::IMM_WIDTH-1:0] idImm;
	logic idUseImm;
	logic memRead;
	logic memWrite;
	logic wbWrite;
	logic branchInId;
	pipePkg::fwdSelT fwdA;
	pipePkg::fwdSelT fwdB;
	pipePkg::fwdSelT fwdC;
	pipePkg::fwdSelT fwdD;
	logic [DATA_WIDTH-1:0] exAluResult;
	logic [DATA_WIDTH-1:0] exmemResult;
	logic [DATA_WIDTH-1:0] exmemStoreData;

	hazardIf hzBus ();

	pipeControl u_control (
		.clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid), .stall(stall),
		.hz(hzBus.ctrl), .rsAddr(rsAddr), .rtAddr(rtAddr), .idOp(idOp), .idImm(idImm),
		.idUseImm(idUseImm), .memRead(memRead), .memWrite(memWrite), .wbWrite(wbWrite),
		.wbRd(wbRd), .wbValid(wbValid), .branchInId(branchInId)
	);

	forwardUnit u_forward (
		.reset(reset), .hz(hzBus.fwd), .fwdA(fwdA), .fwdB(fwdB), .fwdC(fwdC), .fwdD(fwdD)
	);

	regFile #(.DATA_WIDTH(DATA_WIDTH)) u_regFile (
		.clk(clk), .reset(reset), .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData),
		.rtData(rtData), .wbWrite(wbWrite), .wbRd(wbRd), .wbData(wbData)
	);

	branchResolve #(.DATA_WIDTH(DATA_WIDTH)) u_branch (
		.clk(clk), .reset(reset), .branchInId(branchInId), .stall(stall), .rsData(rsData),
		.rtData(rtData), .idImm(idImm), .fwdC(fwdC), .fwdD(fwdD), .exAluResult(exAluResult),
		.exmemResult(exmemResult), .wbData(wbData), .branchValid(branchValid),
		.branchTaken(branchTaken), .branchTarget(branchTarget)
	);

	aluExecute #(.DATA_WIDTH(DATA_WIDTH)) u_alu (
		.clk(clk), .reset(reset), .stall(stall), .rsData(rsData), .rtData(rtData),
		.idOp(idOp), .idImm(idImm), .idUseImm(idUseImm), .fwdA(fwdA), .fwdB(fwdB),
		.wbData(wbData), .exAluResult(exAluResult), .exmemResult(exmemResult),
		.exmemStoreData(exmemStoreData)
	);

	dataMem #(.DATA_WIDTH(DATA_WIDTH), .MEM_WORDS(MEM_WORDS)) u_dataMem (
		.clk(clk), .reset(reset), .memRead(memRead), .memWrite(memWrite),
		.exmemResult(exmemResult), .exmemStoreData(exmemStoreData), .wbData(wbData)
	);

endmodule

// ==== verif/pipeCoreTests.svh ====
function automatic pipePkg::instrT buildInstr(input pipePkg::opcodeT op,
	input logic [pipePkg::REG_ADDR_WIDTH-1:0] rs, input logic [pipePkg::REG_ADDR_WIDTH-1:0] rt,
	input logic [pipePkg::REG_ADDR_WIDTH-1:0] rd, input logic signed [pipePkg::IMM_WIDTH-1:0] imm);
	pipePkg::instrT ins;
	ins.op = op;
	ins.rs = rs;
	ins.rt = rt;
	ins.rd = rd;
	ins.imm = imm;
	return ins;
endfunction

// Model runs first, then the word is held until taken
task automatic issueInstr(input pipePkg::instrT ins);
	logic taken;
	taken = 1'b0;
	modelExecute(ins);
	instr <= ins;
	instrValid <= 1'b1;
	while (!taken) begin
		@(negedge clk);
		taken = !stall;
		@(posedge clk);
	end
endtask

// Idle until every expected report is seen, plus room for stray ones
task automatic waitDrain();
	instrValid <= 1'b0;
	while (expRd.size() != 0 || expTaken.size() != 0)
		@(posedge clk);
	repeat (6) @(posedge clk);
endtask

task automatic testDependences();
	issueInstr(buildInstr(pipePkg::opAdd, 0, 0, 1, 0));
	issueInstr(buildInstr(pipePkg::opSub, 1, 1, 2, 0));
	issueInstr(buildInstr(pipePkg::opAnd, 2, 1, 3, 0));
	issueInstr(buildInstr(pipePkg::opOr, 3, 2, 4, 0));
	issueInstr(buildInstr(pipePkg::opSlt, 4, 3, 5, 0));
	issueInstr(buildInstr(pipePkg::opAdd, 5, 4, 6, 0));
	waitDrain();
endtask

task automatic testRegZero();
	issueInstr(buildInstr(pipePkg::opAdd, 1, 2, 0, 0));
	issueInstr(buildInstr(pipePkg::opOr, 0, 0, 7, 0));
	issueInstr(buildInstr(pipePkg::opLw, 0, 0, 0, 5));
	issueInstr(buildInstr(pipePkg::opSub, 0, 0, 8, 0));
	waitDrain();
endtask

task automatic testLoadUse();
	int stallsBefore;
	stallsBefore = stallCount;
	issueInstr(buildInstr(pipePkg::opSw, 0, 6, 0, 3));
	issueInstr(buildInstr(pipePkg::opLw, 0, 9, 0, 3));
	issueInstr(buildInstr(pipePkg::opAdd, 9, 9, 10, 0));
	issueInstr(buildInstr(pipePkg::opLw, 0, 11, 0, 3));
	issueInstr(buildInstr(pipePkg::opSub, 6, 11, 12, 0));
	waitDrain();
	if (stallCount == stallsBefore)
		failRun("A load followed by its user did not raise stall");
endtask

// Branch sources one, two and three slots back, then from loads
task automatic testBranches();
	issueInstr(buildInstr(pipePkg::opAdd, 1, 2, 12, 0));
	issueInstr(buildInstr(pipePkg::opBeq, 12, 1, 0, 100));
	issueInstr(buildInstr(pipePkg::opAnd, 12, 2, 13, 0));
	issueInstr(buildInstr(pipePkg::opNop, 0, 0, 0, 0));
	issueInstr(buildInstr(pipePkg::opBeq, 13, 0, 0, -7));
	issueInstr(buildInstr(pipePkg::opOr, 13, 12, 14, 0));
	issueInstr(buildInstr(pipePkg::opNop, 0, 0, 0, 0));
	issueInstr(buildInstr(pipePkg::opNop, 0, 0, 0, 0));
	issueInstr(buildInstr(pipePkg::opBeq, 14, 12, 0, 2047));
	issueInstr(buildInstr(pipePkg::opLw, 0, 15, 0, 3));
	issueInstr(buildInstr(pipePkg::opBeq, 15, 0, 0, 55));
	issueInstr(buildInstr(pipePkg::opLw, 0, 16, 0, 4));
	issueInstr(buildInstr(pipePkg::opNop, 0, 0, 0, 0));
	issueInstr(buildInstr(pipePkg::opBeq, 1, 16, 0, -4096));
	waitDrain();
endtask

// Small register range keeps hazards frequent
task automatic testRandomMix();
	pipePkg::instrT ins;
	for (int i = 0; i < RANDOM_INSTRS; i++) begin
		ins.op = pipePkg::opcodeT'(4'($unsigned($random(seed)) % 9));
		ins.rs = pipePkg::REG_ADDR_WIDTH'($random(seed) & 7);
		ins.rt = pipePkg::REG_ADDR_WIDTH'($random(seed) & 7);
		ins.rd = pipePkg::REG_ADDR_WIDTH'($random(seed) & 7);
		ins.imm = pipePkg::IMM_WIDTH'($random(seed));
		issueInstr(ins);
	end
	waitDrain();
endtask

// ==== verif/pipeCoreTb.sv ====
`timescale 1ns/10ps

module pipeCoreTb;

	localparam int DATA_WIDTH = 32;
	localparam int MEM_WORDS = 16;
	localparam int CLK_PERIOD = 40;
	localparam int DIRECTED_INSTRS = 29;
	localparam int RANDOM_INSTRS = 200;
	localparam int TOTAL_INSTRS = DIRECTED_INSTRS + RANDOM_INSTRS;
	localparam int WATCHDOG_MARGIN = 100;

	logic clk;
	logic reset;
	pipePkg::instrT instr;
	logic instrValid;
	logic stall;
	logic wbValid;
	logic [pipePkg::REG_ADDR_WIDTH-1:0] wbRd;
	logic [DATA_WIDTH-1:0] wbData;
	logic branchValid;
	logic branchTaken;
	logic signed [pipePkg::IMM_WIDTH-1:0] branchTarget;

	integer seed;
	int stallCount;

	// Sequential model state and the reports it expects
	logic [DATA_WIDTH-1:0] modelRegs [2 ** pipePkg::REG_ADDR_WIDTH];
	logic [DATA_WIDTH-1:0] modelMem [MEM_WORDS];
	logic [pipePkg::REG_ADDR_WIDTH-1:0] expRd [$];
	logic [DATA_WIDTH-1:0] expData [$];
	logic expTaken [$];
	logic signed [pipePkg::IMM_WIDTH-1:0] expTarget [$];

	pipeCore #(.DATA_WIDTH(DATA_WIDTH), .MEM_WORDS(MEM_WORDS)) u_pipeCore (
		.clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid), .stall(stall),
		.wbValid(wbValid), .wbRd(wbRd), .wbData(wbData), .branchValid(branchValid),
		.branchTaken(branchTaken), .branchTarget(branchTarget)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	function automatic logic [DATA_WIDTH-1:0] modelRead(
		input logic [pipePkg::REG_ADDR_WIDTH-1:0] r);
		return (r == '0) ? '0 : modelRegs[r];
	endfunction

	// Register zero never produces a report
	function automatic void modelWrite(input logic [pipePkg::REG_ADDR_WIDTH-1:0] r,
		input logic [DATA_WIDTH-1:0] v);
		if (r != '0) begin
			modelRegs[r] = v;
			expRd.push_back(r);
			expData.push_back(v);
		end
	endfunction

	function automatic void modelExecute(input pipePkg::instrT ins);
		logic [DATA_WIDTH-1:0] a;
		logic [DATA_WIDTH-1:0] b;
		logic [DATA_WIDTH-1:0] sum;
		int addr;
		a = modelRead(ins.rs);
		b = modelRead(ins.rt);
		sum = a + {{(DATA_WIDTH - pipePkg::IMM_WIDTH){ins.imm[pipePkg::IMM_WIDTH-1]}}, ins.imm};
		addr = int'(sum) & (MEM_WORDS - 1);
		case (ins.op)
			pipePkg::opAdd: modelWrite(ins.rd, a + b);
			pipePkg::opSub: modelWrite(ins.rd, a - b);
			pipePkg::opAnd: modelWrite(ins.rd, a & b);
			pipePkg::opOr: modelWrite(ins.rd, a | b);
			pipePkg::opSlt: modelWrite(ins.rd, ($signed(a) < $signed(b)) ? 1 : 0);
			pipePkg::opLw: modelWrite(ins.rt, modelMem[addr]);
			pipePkg::opSw: modelMem[addr] = b;
			pipePkg::opBeq: begin
				expTaken.push_back(a == b);
				expTarget.push_back(ins.imm);
			end
			default: ;
		endcase
	endfunction

	task automatic compareWrite(input logic [pipePkg::REG_ADDR_WIDTH-1:0] rd,
		input logic [DATA_WIDTH-1:0] data);
		logic [pipePkg::REG_ADDR_WIDTH-1:0] eRd;
		logic [DATA_WIDTH-1:0] eData;
		if (expRd.size() == 0) begin
			failRun($sformatf("Write report to r%0d arrived with no write expected", rd));
		end else begin
			eRd = expRd.pop_front();
			eData = expData.pop_front();
			if (rd !== eRd || data !== eData)
				failRun($sformatf("Mismatch at %0t: write r%0d=%h, expected r%0d=%h",
					$time, rd, data, eRd, eData));
		end
	endtask

	task automatic compareBranch(input logic taken,
		input logic signed [pipePkg::IMM_WIDTH-1:0] target);
		logic eTaken;
		logic signed [pipePkg::IMM_WIDTH-1:0] eTarget;
		if (expTaken.size() == 0) begin
			failRun("Branch report arrived with no branch expected");
		end else begin
			eTaken = expTaken.pop_front();
			eTarget = expTarget.pop_front();
			if (taken !== eTaken || target !== eTarget)
				failRun($sformatf("Mismatch at %0t: branch taken=%b target=%0d, expected %b %0d",
					$time, taken, target, eTaken, eTarget));
		end
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk) begin
		if (reset === 1'b1) begin
			if (wbValid === 1'b1)
				compareWrite(wbRd, wbData);
			if (branchValid === 1'b1)
				compareBranch(branchTaken, branchTarget);
			if (stall === 1'b1)
				stallCount++;
		end
	end

	`include "pipeCoreTests.svh"

	initial begin
		#(CLK_PERIOD * (5 * TOTAL_INSTRS + WATCHDOG_MARGIN));
		failRun("Timeout: the pipeline did not finish all reports in time");
	end

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		seed = 32'h380d;
		stallCount = 0;
		for (int i = 0; i < 2 ** pipePkg::REG_ADDR_WIDTH; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			modelMem[i] = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b1;
		testDependences();
		testRegZero();
		testLoadUse();
		testBranches();
		testRandomMix();
		if (expRd.size() == 0 && expTaken.size() == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			failRun("Expected reports were still pending at the end of the run");
		end
	end

endmodule

// ==== all.f ====
+incdir+verif
verilog/pipePkg.sv
verilog/hazardIf.sv
verilog/forwardUnit.sv
verilog/regFile.sv
verilog/branchResolve.sv
verilog/aluExecute.sv
verilog/dataMem.sv
verilog/pipeControl.sv
verilog/pipeCore.sv
verif/pipeCoreTb.sv
